/* Bender.yml */
# uniform spike generator array with a shared state ram
package:
  name: spike_source

sources:
  # package first, then leaf modules, then the top level
  - hw/spike_pkg.sv
  - hw/spike_state_ram.sv
  - hw/spike_config_regs.sv
  - hw/spike_sweep.sv
  - hw/spike_source_top.sv
  # simulation only
  - target: test
    files:
      - test/spike_tb.sv

/* hw/spike_config_regs.sv */
`default_nettype none

module spike_config_regs #(
  parameter int gen_idx_w = 5
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   prog_valid,
  input  spike_pkg::prog_kind_t  prog_kind,
  input  logic [gen_idx_w-1:0]   prog_addr,
  input  spike_pkg::gen_word_t   prog_word,
  output logic                   prog_ready,
  input  logic                   busy,
  input  logic                   unit_pulse,
  output logic                   ram_load,
  output logic [gen_idx_w-1:0]   load_addr,
  output spike_pkg::gen_word_t   load_word,
  output logic [gen_idx_w:0]     gens_used
);
  import spike_pkg::*;

  // one buffered programming command
  typedef struct packed {
    prog_kind_t           kind;
    logic [gen_idx_w-1:0] addr;
    gen_word_t            word;
  } prog_cmd_t;

  prog_cmd_t cmd_q;
  logic      cmd_full;
  logic      prog_take;
  logic      cmd_go;

  // buffer accepts only when empty
  assign prog_ready = ~cmd_full;
  assign prog_take  = prog_valid & prog_ready;

  // release only while the sweep is idle and not about to start
  // a pulse in this cycle would start a sweep at the next edge
  assign cmd_go = cmd_full & ~busy & ~unit_pulse;

  // a load becomes a single write strobe toward the ram
  assign ram_load  = cmd_go & (cmd_q.kind == load_gen);
  assign load_addr = cmd_q.addr;
  assign load_word = cmd_q.word;

  // buffer occupancy and generators in use
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd_full  <= 1'b0;
      gens_used <= '0;
    end else begin
      if (prog_take) begin
        cmd_full <= 1'b1;
      end else if (cmd_go) begin
        cmd_full <= 1'b0;
      end
      // count comes from the low bits of the tick field
      if (cmd_go && cmd_q.kind == set_used) begin
        gens_used <= cmd_q.word.tick[gen_idx_w:0];
      end
    end
  end

  // command payload, captured on acceptance
  always_ff @(posedge clk) begin
    if (prog_take) begin
      cmd_q <= '{kind: prog_kind, addr: prog_addr, word: prog_word};
    end
  end

endmodule

`default_nettype wire

/* hw/spike_pkg.sv */
`default_nettype none

package spike_pkg;

  // width of the tick counter and of the period it wraps at
  localparam int tick_w = 16;

  // pending spike count per generator
  localparam int count_w = 8;

  // target tag carried by every event of a generator
  localparam int tag_w = 10;

  // one generator as stored in the state ram
  // tick and count change every sweep
  // period, enable and tag change only when programmed
  typedef struct packed {
    logic [tick_w-1:0]  tick;
    logic [tick_w-1:0]  period;
    logic               enable;
    logic [tag_w-1:0]   tag;
    logic [count_w-1:0] count;
  } gen_word_t;

  // one output event
  typedef struct packed {
    logic [tag_w-1:0]   tag;
    logic [count_w-1:0] count;
  } spike_event_t;

  // programming command kinds
  // load_gen writes the whole word at the command address
  // set_used takes the number of generators in use from the low bits of the word's tick field
  typedef enum logic {
    load_gen = 1'b0,
    set_used = 1'b1
  } prog_kind_t;

endpackage

`default_nettype wire

/* hw/spike_source_top.sv */
`default_nettype none

module spike_source_top #(
  parameter int gen_idx_w = 5
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    unit_pulse,
  // programming channel
  input  logic                    prog_valid,
  input  spike_pkg::prog_kind_t   prog_kind,
  input  logic [gen_idx_w-1:0]    prog_addr,
  input  spike_pkg::gen_word_t    prog_word,
  output logic                    prog_ready,
  // event channel
  output logic                    out_valid,
  input  logic                    out_ready,
  output spike_pkg::spike_event_t out_event,
  output logic                    overrun
);
  import spike_pkg::*;

  // config to sweep
  logic                 ram_load;
  logic [gen_idx_w-1:0] load_addr;
  gen_word_t            load_word;
  logic [gen_idx_w:0]   gens_used;
  logic                 busy;

  // sweep to ram
  logic                 rd_en;
  logic [gen_idx_w-1:0] rd_addr;
  gen_word_t            rd_word;
  logic                 wr_en;
  logic [gen_idx_w-1:0] wr_addr;
  logic                 wr_full;
  gen_word_t            wr_word;

  spike_config_regs #(.gen_idx_w(gen_idx_w)) u_config (
    .clk        (clk),
    .reset      (reset),
    .prog_valid (prog_valid),
    .prog_kind  (prog_kind),
    .prog_addr  (prog_addr),
    .prog_word  (prog_word),
    .prog_ready (prog_ready),
    .busy       (busy),
    .unit_pulse (unit_pulse),
    .ram_load   (ram_load),
    .load_addr  (load_addr),
    .load_word  (load_word),
    .gens_used  (gens_used)
  );

  spike_sweep #(.gen_idx_w(gen_idx_w)) u_sweep (
    .clk        (clk),
    .reset      (reset),
    .unit_pulse (unit_pulse),
    .gens_used  (gens_used),
    .ram_load   (ram_load),
    .load_addr  (load_addr),
    .load_word  (load_word),
    .busy       (busy),
    .overrun    (overrun),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_word    (rd_word),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_full    (wr_full),
    .wr_word    (wr_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_event  (out_event)
  );

  spike_state_ram #(.gen_idx_w(gen_idx_w)) u_ram (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_word (rd_word),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_full (wr_full),
    .wr_word (wr_word)
  );

endmodule

`default_nettype wire

/* hw/spike_state_ram.sv */
`default_nettype none

module spike_state_ram #(
  parameter int gen_idx_w = 5
) (
  input  logic                   clk,
  input  logic                   rd_en,
  input  logic [gen_idx_w-1:0]   rd_addr,
  output spike_pkg::gen_word_t   rd_word,
  input  logic                   wr_en,
  input  logic [gen_idx_w-1:0]   wr_addr,
  input  logic                   wr_full,
  input  spike_pkg::gen_word_t   wr_word
);
  import spike_pkg::*;

  localparam int depth = 2 ** gen_idx_w;

  // tick and count live in one bank, written on every write
  localparam int dyn_w = tick_w + count_w;
  // period, enable and tag live in the other, written only on a full write
  localparam int cfg_w = tick_w + 1 + tag_w;

  logic [dyn_w-1:0] dyn_mem [depth];
  logic [cfg_w-1:0] cfg_mem [depth];

  // registered read data of both banks
  logic [dyn_w-1:0] dyn_q;
  logic [cfg_w-1:0] cfg_q;

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      dyn_mem[wr_addr] <= {wr_word.tick, wr_word.count};
      // field mask selects whether the static fields follow
      if (wr_full) begin
        cfg_mem[wr_addr] <= {wr_word.period, wr_word.enable, wr_word.tag};
      end
    end
  end

  // read port with one cycle of latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      dyn_q <= dyn_mem[rd_addr];
      cfg_q <= cfg_mem[rd_addr];
    end
  end

  // reassemble the generator word from both banks
  assign rd_word = '{
    tick:   dyn_q[dyn_w-1 -: tick_w],
    period: cfg_q[cfg_w-1 -: tick_w],
    enable: cfg_q[tag_w],
    tag:    cfg_q[tag_w-1:0],
    count:  dyn_q[count_w-1:0]
  };

endmodule

`default_nettype wire

/* hw/spike_sweep.sv */
`default_nettype none

module spike_sweep #(
  parameter int gen_idx_w = 5
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    unit_pulse,
  input  logic [gen_idx_w:0]      gens_used,
  input  logic                    ram_load,
  input  logic [gen_idx_w-1:0]    load_addr,
  input  spike_pkg::gen_word_t    load_word,
  output logic                    busy,
  output logic                    overrun,
  // ram read port
  output logic                    rd_en,
  output logic [gen_idx_w-1:0]    rd_addr,
  input  spike_pkg::gen_word_t    rd_word,
  // ram write port
  output logic                    wr_en,
  output logic [gen_idx_w-1:0]    wr_addr,
  output logic                    wr_full,
  output spike_pkg::gen_word_t    wr_word,
  // passive event output
  output logic                    out_valid,
  input  logic                    out_ready,
  output spike_pkg::spike_event_t out_event
);
  import spike_pkg::*;

  // idle       waits for unit_pulse and passes program loads to the ram
  // first_read reads generator 0 with nothing to write yet
  // update     reads one generator and writes back the one before it
  // last_write writes back the final generator
  typedef enum logic [1:0] {
    idle,
    first_read,
    update,
    last_write
  } sweep_state_t;

  sweep_state_t state;
  sweep_state_t state_next;

  // index being read and index being written back
  logic [gen_idx_w-1:0] rd_idx;
  logic [gen_idx_w-1:0] wb_idx;
  logic [gen_idx_w:0]   rd_idx_p1;
  logic                 last_read;
  logic                 sweep_start;
  logic                 deciding;

  // update datapath
  logic [tick_w-1:0]  next_tick;
  logic [count_w-1:0] next_count;
  logic [count_w-1:0] count_p1;
  logic [count_w-1:0] send_count;
  logic               send;

  assign busy = (state != idle);

  // extra bit so a full table of 2**gen_idx_w generators compares correctly
  assign rd_idx_p1 = {1'b0, rd_idx} + 1'b1;
  assign last_read = (rd_idx_p1 == gens_used);

  // nothing to sweep when no generator is in use
  assign sweep_start = unit_pulse & (gens_used != '0);

  // read data of the previous cycle is valid in these states
  assign deciding = (state == update) || (state == last_write);

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (sweep_start) begin
          state_next = first_read;
        end
      end
      first_read, update: begin
        if (last_read) begin
          state_next = last_write;
        end else begin
          state_next = update;
        end
      end
      last_write: begin
        state_next = idle;
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= idle;
      rd_idx  <= '0;
      wb_idx  <= '0;
      overrun <= 1'b0;
    end else begin
      state  <= state_next;
      wb_idx <= rd_idx;
      // walk forward while reading, rewind otherwise
      if (state == first_read || state == update) begin
        rd_idx <= rd_idx_p1[gen_idx_w-1:0];
      end else begin
        rd_idx <= '0;
      end
      // a pulse during a sweep is dropped but remembered
      if (unit_pulse && busy) begin
        overrun <= 1'b1;
      end
    end
  end

  // saturating increment of the pending count
  assign count_p1 = (rd_word.count == '1) ? rd_word.count : rd_word.count + 1'b1;

  // per generator decision on the word just read
  always_comb begin
    next_tick  = rd_word.tick;
    next_count = rd_word.count;
    send_count = rd_word.count;
    send       = 1'b0;
    if (rd_word.enable) begin
      if (rd_word.tick < rd_word.period) begin
        next_tick = rd_word.tick + 1'b1;
        // flush any leftover count if the output takes it
        if (rd_word.count != '0 && out_ready) begin
          send       = 1'b1;
          next_count = '0;
        end
      end else begin
        // tick wraps and adds one spike
        next_tick  = {{(tick_w-1){1'b0}}, 1'b1};
        send_count = count_p1;
        if (out_ready) begin
          send       = 1'b1;
          next_count = '0;
        end else begin
          next_count = count_p1;
        end
      end
    end
  end

  // valid only rises together with ready
  assign out_valid = deciding & send;
  assign out_event = '{tag: rd_word.tag, count: send_count};

  // read port follows the read index
  assign rd_en   = (state == first_read) || (state == update);
  assign rd_addr = rd_idx;

  // write port is shared by program loads and the writeback
  always_comb begin
    wr_en   = 1'b0;
    wr_addr = wb_idx;
    wr_full = 1'b0;
    wr_word = rd_word;
    if (deciding) begin
      // only tick and count go back to the ram
      wr_en        = 1'b1;
      wr_word.tick  = next_tick;
      wr_word.count = next_count;
    end else if (state == idle) begin
      wr_en   = ram_load;
      wr_addr = load_addr;
      wr_full = 1'b1;
      wr_word = load_word;
    end
  end

endmodule

`default_nettype wire

/* spike_source_top.f */
hw/spike_pkg.sv
hw/spike_state_ram.sv
hw/spike_config_regs.sv
hw/spike_sweep.sv
hw/spike_source_top.sv
test/spike_tb.sv

/* test/spike_tb.sv */
`default_nettype none

module spike_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import spike_pkg::*;

  localparam int gen_idx_w = 5;
  localparam int table_gens = 16;
  // each sweep takes at most gens_used plus four cycles with its gap
  localparam int sweep_cycles = 12*16 + 20*16 + 6*20 + 6*9 + 9*12 + 5*12;
  // about forty commands of four cycles each plus reset
  localparam int prog_cycles = 40*4 + 20;
  localparam int cycle_limit = 2*sweep_cycles + prog_cycles;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 unit_pulse;
  logic                 prog_valid;
  prog_kind_t           prog_kind;
  logic [gen_idx_w-1:0] prog_addr;
  gen_word_t            prog_word;
  logic                 prog_ready;
  logic                 out_valid;
  logic                 out_ready;
  spike_event_t         out_event;
  logic                 overrun;

  // reference model of the generator table and the event stream
  gen_word_t    model [table_gens];
  int           gens_used_m;
  logic         overrun_m;
  spike_event_t exp_q [$];
  spike_event_t exp_ev;
  gen_word_t    new_word;

  logic [31:0] seed = 32'h18f7_1a36;
  string       test_name = "reset";
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          held_cycles;

  spike_source_top #(.gen_idx_w(gen_idx_w)) DUT (
    .clk        (clk),
    .reset      (reset),
    .unit_pulse (unit_pulse),
    .prog_valid (prog_valid),
    .prog_kind  (prog_kind),
    .prog_addr  (prog_addr),
    .prog_word  (prog_word),
    .prog_ready (prog_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_event  (out_event),
    .overrun    (overrun)
  );

  always #5 clk = ~clk;

  // watchdog on total run length
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles in test %s", cycles, test_name);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // event taken on an edge with valid and ready both high
  always @(posedge clk) begin
    if (!reset && out_valid) begin
      if (!out_ready) begin
        errors++;
        $display("%s: out_valid high while out_ready is low", test_name);
      end else if (exp_q.size() == 0) begin
        errors++;
        $display("%s: unexpected event tag %0d count %0d", test_name,
                 out_event.tag, out_event.count);
      end else begin
        exp_ev = exp_q.pop_front();
        checks++;
        if (out_event !== exp_ev) begin
          errors++;
          $display("ERROR %s: expected tag %0d count %0d, actual tag %0d count %0d",
                   test_name, exp_ev.tag, exp_ev.count, out_event.tag, out_event.count);
        end
      end
    end
  end

  // 32 bit lcg with the numerical recipes constants
  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = rand_next();
    return int'(r[30:16]) % n;
  endfunction

  // one generator update as seen at its decision cycle
  task automatic decide(input int idx, input logic rdy);
    gen_word_t          g;
    logic [count_w-1:0] c;
    g = model[idx];
    if (g.enable) begin
      if (g.tick < g.period) begin
        g.tick = g.tick + 16'd1;
        if (g.count != '0 && rdy) begin
          exp_q.push_back('{tag: g.tag, count: g.count});
          g.count = '0;
        end
      end else begin
        g.tick = 16'd1;
        c = (g.count == '1) ? g.count : g.count + 8'd1;
        if (rdy) begin
          exp_q.push_back('{tag: g.tag, count: c});
          g.count = '0;
        end else begin
          g.count = c;
        end
      end
    end
    model[idx] = g;
  endtask

  // offer a command and wait until the buffer has drained into the design
  task automatic prog_cmd(input prog_kind_t kind, input logic [gen_idx_w-1:0] addr,
                          input gen_word_t word);
    prog_valid = 1'b1;
    prog_kind  = kind;
    prog_addr  = addr;
    prog_word  = word;
    while (!prog_ready) @(negedge clk);
    @(negedge clk);
    prog_valid = 1'b0;
    held_cycles = 0;
    while (!prog_ready) begin
      if (DUT.busy) held_cycles++;
      @(negedge clk);
    end
    checks++;
    if (DUT.busy) begin
      errors++;
      $display("%s: prog_ready rose while a sweep was running", test_name);
    end
  endtask

  task automatic load_random(input int idx, input logic all_on);
    gen_word_t   w;
    logic [31:0] r;
    w.tick   = 16'd1;
    w.period = 16'(rand_below(6) + 1);
    r        = rand_next();
    w.tag    = r[25:16];
    // about three in four stay enabled
    w.enable = all_on || (r[31:30] != 2'b00);
    w.count  = '0;
    prog_cmd(load_gen, idx[gen_idx_w-1:0], w);
    model[idx] = w;
  endtask

  task automatic set_gens_used(input int n);
    gen_word_t w;
    w      = '0;
    w.tick = 16'(n);
    prog_cmd(set_used, '0, w);
    gens_used_m = n;
  endtask

  task automatic run_sweep(input logic random_ready, input logic extra_pulse);
    int          n;
    logic        rdy;
    logic [31:0] r;
    n = gens_used_m;
    unit_pulse = 1'b1;
    @(negedge clk);
    unit_pulse = 1'b0;
    // ready driven at negedge k is sampled at the writeback edge of generator k-1
    for (int k = 1; k <= n; k++) begin
      @(negedge clk);
      r = rand_next();
      rdy = random_ready ? r[20] : 1'b1;
      out_ready = rdy;
      unit_pulse = extra_pulse && (k == 1);
      if (extra_pulse && k == 1) overrun_m = 1'b1;
      decide(k - 1, rdy);
    end
    @(negedge clk);
    unit_pulse = 1'b0;
    checks++;
    if (DUT.busy !== 1'b0) begin
      errors++;
      $display("%s: sweep still busy %0d cycles after its pulse", test_name, n + 2);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d expected events never appeared", test_name, exp_q.size());
      exp_q.delete();
    end
    if (overrun !== overrun_m) begin
      errors++;
      $display("ERROR %s: overrun expected %0b actual %0b", test_name, overrun_m, overrun);
    end
  endtask

  task automatic run_sweeps(input int count, input logic random_ready);
    int gap;
    for (int s = 0; s < count; s++) begin
      run_sweep(random_ready, 1'b0);
      gap = rand_below(3);
      repeat (gap) @(negedge clk);
    end
  endtask

  initial begin
    reset       = 1'b1;
    unit_pulse  = 1'b0;
    prog_valid  = 1'b0;
    prog_kind   = load_gen;
    prog_addr   = '0;
    prog_word   = '0;
    out_ready   = 1'b1;
    overrun_m   = 1'b0;
    gens_used_m = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checks++;
    if (prog_ready !== 1'b1 || out_valid !== 1'b0 || overrun !== 1'b0) begin
      errors++;
      $display("outputs not at their reset values after reset");
    end

    test_name = "basic";
    for (int i = 0; i < table_gens; i++) load_random(i, 1'b1);
    set_gens_used(12);
    run_sweeps(12, 1'b0);

    test_name = "backpressure";
    run_sweeps(20, 1'b1);

    test_name = "enable_used";
    for (int i = 0; i < table_gens; i++) load_random(i, 1'b0);
    set_gens_used(16);
    run_sweeps(6, 1'b1);
    set_gens_used(5);
    run_sweeps(6, 1'b0);

    // reload generator 2 while a sweep is running
    test_name = "prog_in_sweep";
    set_gens_used(8);
    new_word = '{tick: 16'd1, period: 16'(rand_below(6) + 1), enable: 1'b1,
                 tag: 10'h2a5, count: '0};
    fork
      run_sweep(1'b1, 1'b0);
      begin
        repeat (3) @(negedge clk);
        prog_cmd(load_gen, 5'd2, new_word);
      end
    join
    model[2] = new_word;
    // the load accepted at the third edge of the sweep waits out its remaining busy cycles
    checks++;
    if (held_cycles != gens_used_m - 2) begin
      errors++;
      $display("ERROR %s: busy cycles with the load held expected %0d actual %0d",
               test_name, gens_used_m - 2, held_cycles);
    end
    run_sweeps(8, 1'b0);

    test_name = "overrun";
    run_sweep(1'b0, 1'b1);
    run_sweeps(4, 1'b1);

    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
